/* cache_pkg.sv */
package cache_pkg;

   // address and data geometry
   localparam int ADDR_W   = 12;
   localparam int DATA_W   = 32;
   localparam int NBYTES   = DATA_W / 8;
   localparam int OFFSET_W = 2;
   localparam int INDEX_W  = 4;
   localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
   localparam int NSETS    = 1 << INDEX_W;

   // associativity
   localparam int NWAYS = 2;
   localparam int WAY_W = (NWAYS > 1) ? $clog2(NWAYS) : 1;

   // write-through buffer
   localparam int WTB_DEPTH = 4;
   localparam int WTB_PTR_W = $clog2(WTB_DEPTH);

   // controller states
   localparam logic [1:0] CTRL_IDLE  = 2'd0;
   localparam logic [1:0] CTRL_DRAIN = 2'd1;
   localparam logic [1:0] CTRL_FETCH = 2'd2;
   localparam logic [1:0] CTRL_RESP  = 2'd3;

   // backend states
   localparam logic [1:0] BE_IDLE    = 2'd0;
   localparam logic [1:0] BE_RD_REQ  = 2'd1;
   localparam logic [1:0] BE_RD_WAIT = 2'd2;

   // one address word, seen raw or split into its fields
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      struct packed {
         logic [TAG_W-1:0]    tag;
         logic [INDEX_W-1:0]  index;
         logic [OFFSET_W-1:0] offset;
      } f;
   } cache_addr_u;

endpackage

/* cache_way.sv */
`timescale 1ns/1ps

module cache_way import cache_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [ADDR_W-1:0] req_addr_i,
   input  logic [DATA_W-1:0] req_wdata_i,
   input  logic [NBYTES-1:0] req_wstrb_i,
   input  logic              wr_upd_i,
   input  logic              refill_en_i,
   input  logic [DATA_W-1:0] refill_data_i,
   output logic              hit_o,
   output logic [DATA_W-1:0] rdata_o
);

   cache_addr_u       addr;
   logic [NSETS-1:0]  valid_q;
   logic [TAG_W-1:0]  tag_mem  [NSETS];
   logic [DATA_W-1:0] data_mem [NSETS];

   assign addr.raw = req_addr_i;

   // tag compare on the indexed set
   assign hit_o   = valid_q[addr.f.index] & (tag_mem[addr.f.index] == addr.f.tag);
   assign rdata_o = data_mem[addr.f.index];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= '0;
      end else if (refill_en_i) begin
         valid_q[addr.f.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (refill_en_i) begin
         tag_mem[addr.f.index]  <= addr.f.tag;
         data_mem[addr.f.index] <= refill_data_i;
      end else if (wr_upd_i && hit_o) begin
         // only the strobed bytes change
         for (int b = 0; b < NBYTES; b++) begin
            if (req_wstrb_i[b]) begin
               data_mem[addr.f.index][8*b +: 8] <= req_wdata_i[8*b +: 8];
            end
         end
      end
   end

endmodule

/* cache_hit_select.sv */
`timescale 1ns/1ps

module cache_hit_select import cache_pkg::*; (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic [NWAYS-1:0]              way_hit_i,
   input  logic [NWAYS-1:0][DATA_W-1:0]  way_rdata_i,
   input  logic [ADDR_W-1:0]             req_addr_i,
   input  logic                          refill_i,
   output logic                          hit_o,
   output logic [DATA_W-1:0]             hit_data_o,
   output logic [NWAYS-1:0]              victim_o
);

   cache_addr_u      addr;
   logic [WAY_W-1:0] rr_ptr_q [NSETS];
   logic [WAY_W-1:0] cur_ptr;

   assign addr.raw = req_addr_i;
   assign cur_ptr  = rr_ptr_q[addr.f.index];

   assign hit_o = |way_hit_i;

   // at most one way hits, so an and-or mux is enough
   always_comb begin
      hit_data_o = '0;
      for (int w = 0; w < NWAYS; w++) begin
         hit_data_o = hit_data_o | (way_rdata_i[w] & {DATA_W{way_hit_i[w]}});
      end
   end

   // one-hot form of the set's pointer
   always_comb begin
      for (int w = 0; w < NWAYS; w++) begin
         victim_o[w] = (cur_ptr == WAY_W'(w));
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int s = 0; s < NSETS; s++) begin
            rr_ptr_q[s] <= '0;
         end
      end else if (refill_i) begin
         // next way for this set, wrapping after the last
         if (cur_ptr == WAY_W'(NWAYS - 1)) begin
            rr_ptr_q[addr.f.index] <= '0;
         end else begin
            rr_ptr_q[addr.f.index] <= cur_ptr + 1'b1;
         end
      end
   end

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   // cpu side
   input  logic              avalid_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic [NBYTES-1:0] wstrb_i,
   output logic              ready_o,
   output logic              rvalid_o,
   output logic [DATA_W-1:0] rdata_o,
   // to the ways
   output logic [ADDR_W-1:0] req_addr_o,
   output logic [DATA_W-1:0] req_wdata_o,
   output logic [NBYTES-1:0] req_wstrb_o,
   output logic              wr_upd_o,
   output logic [NWAYS-1:0]  refill_en_o,
   output logic [DATA_W-1:0] refill_data_o,
   // from the hit selector
   input  logic              hit_i,
   input  logic [DATA_W-1:0] hit_data_i,
   input  logic [NWAYS-1:0]  victim_i,
   // backend
   output logic              wtb_push_o,
   input  logic              wtb_full_i,
   input  logic              wtb_empty_i,
   output logic              fetch_req_o,
   input  logic              fetch_done_i,
   input  logic [DATA_W-1:0] fetch_data_i
);

   logic [1:0]        state_q;
   logic              req_vld_q;
   logic              req_rd_q;
   cache_addr_u       req_addr_q;
   logic [DATA_W-1:0] req_wdata_q;
   logic [NBYTES-1:0] req_wstrb_q;
   logic              miss;
   logic              can_take;
   logic              accept;

   // held read that found no way with its tag
   assign miss = (state_q == CTRL_IDLE) & req_vld_q & req_rd_q & ~hit_i;

   // a new request may replace the held one
   assign can_take = ((state_q == CTRL_IDLE) & ~miss) | (state_q == CTRL_RESP);
   assign ready_o  = can_take & ~wtb_full_i;
   assign accept   = avalid_i & ready_o;

   // every write goes to the buffer as it is accepted
   assign wtb_push_o = accept & (|wstrb_i);

   // after a refill the victim way hits, so its data is the answer
   assign rvalid_o = req_vld_q & req_rd_q &
                     (((state_q == CTRL_IDLE) & hit_i) | (state_q == CTRL_RESP));
   assign rdata_o  = hit_data_i;

   assign req_addr_o  = req_addr_q.raw;
   assign req_wdata_o = req_wdata_q;
   assign req_wstrb_o = req_wstrb_q;

   // hitting way merges the held write
   assign wr_upd_o = req_vld_q & ~req_rd_q;

   assign fetch_req_o   = (state_q == CTRL_DRAIN) & wtb_empty_i;
   assign refill_en_o   = ((state_q == CTRL_FETCH) & fetch_done_i) ? victim_i : '0;
   assign refill_data_o = fetch_data_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q   <= CTRL_IDLE;
         req_vld_q <= 1'b0;
      end else begin
         if (can_take) begin
            req_vld_q <= accept;
         end
         case (state_q)
            CTRL_IDLE: begin
               if (miss) begin
                  state_q <= CTRL_DRAIN;
               end
            end
            // older writes must reach memory before the fetch
            CTRL_DRAIN: begin
               if (wtb_empty_i) begin
                  state_q <= CTRL_FETCH;
               end
            end
            CTRL_FETCH: begin
               if (fetch_done_i) begin
                  state_q <= CTRL_RESP;
               end
            end
            default: begin
               state_q <= CTRL_IDLE;
            end
         endcase
      end
   end

   // request payload
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_rd_q       <= ~(|wstrb_i);
         req_addr_q.raw <= addr_i;
         req_wdata_q    <= wdata_i;
         req_wstrb_q    <= wstrb_i;
      end
   end

endmodule

/* cache_backend.sv */
`timescale 1ns/1ps

module cache_backend import cache_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   // write-through buffer push
   input  logic              push_i,
   input  logic [ADDR_W-1:0] push_addr_i,
   input  logic [DATA_W-1:0] push_wdata_i,
   input  logic [NBYTES-1:0] push_wstrb_i,
   output logic              wtb_full_o,
   output logic              wtb_empty_o,
   // refill read
   input  logic              fetch_req_i,
   input  logic [ADDR_W-1:0] fetch_addr_i,
   output logic              fetch_done_o,
   output logic [DATA_W-1:0] fetch_data_o,
   // back-end memory
   output logic              be_avalid_o,
   output logic [ADDR_W-1:0] be_addr_o,
   output logic [DATA_W-1:0] be_wdata_o,
   output logic [NBYTES-1:0] be_wstrb_o,
   input  logic              be_ready_i,
   input  logic              be_rvalid_i,
   input  logic [DATA_W-1:0] be_rdata_i
);

   logic [1:0]           state_q;
   cache_addr_u          fifo_addr [WTB_DEPTH];
   logic [DATA_W-1:0]    fifo_data [WTB_DEPTH];
   logic [NBYTES-1:0]    fifo_strb [WTB_DEPTH];
   logic [WTB_PTR_W-1:0] wr_ptr_q;
   logic [WTB_PTR_W-1:0] rd_ptr_q;
   logic [WTB_PTR_W:0]   count_q;
   logic                 wr_sel;
   logic                 rd_sel;
   logic                 pop;

   assign wtb_empty_o = (count_q == '0);
   assign wtb_full_o  = (count_q == (WTB_PTR_W + 1)'(WTB_DEPTH));

   // buffered writes go first, the refill read only once all have drained
   assign wr_sel = ~wtb_empty_o & (state_q != BE_RD_WAIT);
   assign rd_sel = wtb_empty_o & (state_q == BE_RD_REQ);
   assign pop    = wr_sel & be_ready_i;

   // head entry stays put until memory takes it
   assign be_avalid_o = wr_sel | rd_sel;
   assign be_addr_o   = wr_sel ? fifo_addr[rd_ptr_q].raw : fetch_addr_i;
   assign be_wdata_o  = wr_sel ? fifo_data[rd_ptr_q] : '0;
   assign be_wstrb_o  = wr_sel ? fifo_strb[rd_ptr_q] : '0;

   assign fetch_done_o = (state_q == BE_RD_WAIT) & be_rvalid_i;
   assign fetch_data_o = be_rdata_i;

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         fifo_addr[wr_ptr_q].raw <= push_addr_i;
         fifo_data[wr_ptr_q]     <= push_wdata_i;
         fifo_strb[wr_ptr_q]     <= push_wstrb_i;
      end
   end

   // pointers wrap on their own with a power-of-two depth
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_i, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // refill read sequencing
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= BE_IDLE;
      end else begin
         case (state_q)
            BE_IDLE: begin
               if (fetch_req_i) begin
                  state_q <= BE_RD_REQ;
               end
            end
            BE_RD_REQ: begin
               if (rd_sel && be_ready_i) begin
                  state_q <= BE_RD_WAIT;
               end
            end
            BE_RD_WAIT: begin
               if (be_rvalid_i) begin
                  state_q <= BE_IDLE;
               end
            end
            default: begin
               state_q <= BE_IDLE;
            end
         endcase
      end
   end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   // cpu port
   input  logic              avalid_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic [NBYTES-1:0] wstrb_i,
   output logic              ready_o,
   output logic              rvalid_o,
   output logic [DATA_W-1:0] rdata_o,
   // back-end port
   output logic              be_avalid_o,
   output logic [ADDR_W-1:0] be_addr_o,
   output logic [DATA_W-1:0] be_wdata_o,
   output logic [NBYTES-1:0] be_wstrb_o,
   input  logic              be_ready_i,
   input  logic              be_rvalid_i,
   input  logic [DATA_W-1:0] be_rdata_i
);

   logic [ADDR_W-1:0]             req_addr;
   logic [DATA_W-1:0]             req_wdata;
   logic [NBYTES-1:0]             req_wstrb;
   logic                          wr_upd;
   logic [NWAYS-1:0]              refill_en;
   logic [DATA_W-1:0]             refill_data;
   logic [NWAYS-1:0]              way_hit;
   logic [NWAYS-1:0][DATA_W-1:0]  way_rdata;
   logic                          hit;
   logic [DATA_W-1:0]             hit_data;
   logic [NWAYS-1:0]              victim;
   logic                          wtb_push;
   logic                          wtb_full;
   logic                          wtb_empty;
   logic                          fetch_req;
   logic                          fetch_done;
   logic [DATA_W-1:0]             fetch_data;

   cache_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .avalid_i     (avalid_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .ready_o      (ready_o),
      .rvalid_o     (rvalid_o),
      .rdata_o      (rdata_o),
      .req_addr_o   (req_addr),
      .req_wdata_o  (req_wdata),
      .req_wstrb_o  (req_wstrb),
      .wr_upd_o     (wr_upd),
      .refill_en_o  (refill_en),
      .refill_data_o(refill_data),
      .hit_i        (hit),
      .hit_data_i   (hit_data),
      .victim_i     (victim),
      .wtb_push_o   (wtb_push),
      .wtb_full_i   (wtb_full),
      .wtb_empty_i  (wtb_empty),
      .fetch_req_o  (fetch_req),
      .fetch_done_i (fetch_done),
      .fetch_data_i (fetch_data)
   );

   for (genvar w = 0; w < NWAYS; w++) begin : g_way
      cache_way u_way (
         .clk_i        (clk_i),
         .rst_i        (rst_i),
         .req_addr_i   (req_addr),
         .req_wdata_i  (req_wdata),
         .req_wstrb_i  (req_wstrb),
         .wr_upd_i     (wr_upd),
         .refill_en_i  (refill_en[w]),
         .refill_data_i(refill_data),
         .hit_o        (way_hit[w]),
         .rdata_o      (way_rdata[w])
      );
   end

   cache_hit_select u_hit_select (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .way_hit_i  (way_hit),
      .way_rdata_i(way_rdata),
      .req_addr_i (req_addr),
      .refill_i   (|refill_en),
      .hit_o      (hit),
      .hit_data_o (hit_data),
      .victim_o   (victim)
   );

   // writes enter the buffer straight from the cpu port
   cache_backend u_backend (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (wtb_push),
      .push_addr_i (addr_i),
      .push_wdata_i(wdata_i),
      .push_wstrb_i(wstrb_i),
      .wtb_full_o  (wtb_full),
      .wtb_empty_o (wtb_empty),
      .fetch_req_i (fetch_req),
      .fetch_addr_i(req_addr),
      .fetch_done_o(fetch_done),
      .fetch_data_o(fetch_data),
      .be_avalid_o (be_avalid_o),
      .be_addr_o   (be_addr_o),
      .be_wdata_o  (be_wdata_o),
      .be_wstrb_o  (be_wstrb_o),
      .be_ready_i  (be_ready_i),
      .be_rvalid_i (be_rvalid_i),
      .be_rdata_i  (be_rdata_i)
   );

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model import cache_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              stall_i,
   input  logic              avalid_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic [NBYTES-1:0] wstrb_i,
   output logic              ready_o,
   output logic              rvalid_o,
   output logic [DATA_W-1:0] rdata_o
);

   localparam int WORD_AW = ADDR_W - OFFSET_W;

   logic [DATA_W-1:0]  mem [1 << WORD_AW];
   logic [WORD_AW-1:0] rd_word_q;
   logic [7:0]         rd_req_q;
   logic [7:0]         rd_ack_q;
   int                 wait_q;
   integer             seed;

   function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_AW-1:0] w);
      return {6'h2a, w, 6'h15, ~w};
   endfunction

   initial begin
      seed     = 32'h4aeef63b;
      ready_o  = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      for (int i = 0; i < (1 << WORD_AW); i++) begin
         mem[i] = fill_word(WORD_AW'(i));
      end
   end

   // transfer taken on an edge with valid and ready both high
   always @(posedge clk_i) begin
      if (rst_i) begin
         rd_req_q = '0;
      end else if (avalid_i && ready_o) begin
         if (wstrb_i != '0) begin
            for (int b = 0; b < NBYTES; b++) begin
               if (wstrb_i[b]) begin
                  mem[addr_i[ADDR_W-1:OFFSET_W]][8*b +: 8] = wdata_i[8*b +: 8];
               end
            end
         end else begin
            rd_word_q = addr_i[ADDR_W-1:OFFSET_W];
            rd_req_q  = rd_req_q + 8'd1;
         end
      end
   end

   // ready and read response change on the falling edge
   always @(negedge clk_i) begin
      if (rst_i) begin
         ready_o  = 1'b0;
         rvalid_o = 1'b0;
         rd_ack_q = '0;
         wait_q   = 2;
      end else begin
         ready_o  = ~stall_i & (($random(seed) & 3) != 0);
         rvalid_o = 1'b0;
         if (rd_ack_q != rd_req_q) begin
            if (wait_q == 0) begin
               rvalid_o = 1'b1;
               rdata_o  = mem[rd_word_q];
               rd_ack_q = rd_req_q;
               wait_q   = $random(seed) & 3;
            end else begin
               wait_q = wait_q - 1;
            end
         end
      end
   end

endmodule

/* cache_tb.sv */
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

   localparam int OP_RD    = 0;
   localparam int OP_WR    = 1;
   localparam int OP_DRAIN = 2;
   localparam int OP_FULL  = 3;
   localparam int NUM_ENT  = 19;
   // cycle budget per table entry including drains and misses
   localparam int ENT_BOUND = 200;
   localparam int WORD_AW   = ADDR_W - OFFSET_W;

   typedef struct {
      int                op;
      logic              stall;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
      logic              fetch;
   } entry_t;

   logic              clk;
   logic              rst;
   logic              avalid;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [NBYTES-1:0] wstrb;
   logic              ready;
   logic              rvalid;
   logic [DATA_W-1:0] rdata;
   logic              be_avalid;
   logic [ADDR_W-1:0] be_addr;
   logic [DATA_W-1:0] be_wdata;
   logic [NBYTES-1:0] be_wstrb;
   logic              be_ready;
   logic              be_rvalid;
   logic [DATA_W-1:0] be_rdata;
   logic              stall;

   entry_t            tbl [NUM_ENT];
   logic [DATA_W-1:0] shadow [1 << WORD_AW];
   // expected cache state with the valid bit above the tag
   logic [TAG_W:0]    line_m [NWAYS][NSETS];
   int                ptr_m [NSETS];
   logic [ADDR_W-1:0] wq_addr [$];
   logic [DATA_W-1:0] wq_data [$];
   logic [NBYTES-1:0] wq_strb [$];
   logic [ADDR_W-1:0] rd_addr;
   int                wr_issued;
   int                wr_seen = 0;
   int                rd_seen = 0;

   cache_top u_dut (
      .clk_i      (clk),
      .rst_i      (rst),
      .avalid_i   (avalid),
      .addr_i     (addr),
      .wdata_i    (wdata),
      .wstrb_i    (wstrb),
      .ready_o    (ready),
      .rvalid_o   (rvalid),
      .rdata_o    (rdata),
      .be_avalid_o(be_avalid),
      .be_addr_o  (be_addr),
      .be_wdata_o (be_wdata),
      .be_wstrb_o (be_wstrb),
      .be_ready_i (be_ready),
      .be_rvalid_i(be_rvalid),
      .be_rdata_i (be_rdata)
   );

   tb_mem_model u_mem (
      .clk_i   (clk),
      .rst_i   (rst),
      .stall_i (stall),
      .avalid_i(be_avalid),
      .addr_i  (be_addr),
      .wdata_i (be_wdata),
      .wstrb_i (be_wstrb),
      .ready_o (be_ready),
      .rvalid_o(be_rvalid),
      .rdata_o (be_rdata)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   initial begin
      #((NUM_ENT * ENT_BOUND + 10) * 10);
      fail_run("timeout: the stimulus table did not complete in time");
   end

   function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_AW-1:0] w);
      // differs at every word address
      return {6'h2a, w, 6'h15, ~w};
   endfunction

   function automatic int find_way(input logic [ADDR_W-1:0] a_raw);
      cache_addr_u a;
      a.raw = a_raw;
      for (int w = 0; w < NWAYS; w++) begin
         if (line_m[w][a.f.index] == {1'b1, a.f.tag}) begin
            return w;
         end
      end
      return -1;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                        input string what);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: %s, got %h, expected %h",
                            $time, what, got, exp));
      end
   endtask

   // every backend transfer is checked as memory takes it
   always @(posedge clk) begin : be_monitor
      logic [ADDR_W-1:0] exp_a;
      logic [DATA_W-1:0] exp_d;
      logic [NBYTES-1:0] exp_s;
      if (!rst && be_avalid && be_ready) begin
         if (be_wstrb != '0) begin
            if (wq_addr.size() == 0) begin
               fail_run("backend write seen with no write left to drain");
            end else begin
               exp_a = wq_addr.pop_front();
               exp_d = wq_data.pop_front();
               exp_s = wq_strb.pop_front();
               check(32'(be_addr), 32'(exp_a), "backend write address");
               check(be_wdata, exp_d, "backend write data");
               check(32'(be_wstrb), 32'(exp_s), "backend write strobes");
               wr_seen++;
            end
         end else begin
            check(32'(be_addr), 32'(rd_addr), "backend read address");
            rd_seen++;
         end
      end
   end

   task automatic wait_drained();
      while (wr_seen != wr_issued) begin
         @(negedge clk);
      end
   endtask

   task automatic write_entry(input entry_t e);
      logic [WORD_AW-1:0] w;
      w = e.addr[ADDR_W-1:OFFSET_W];
      if (e.stall && !stall) begin
         // stalled run starts from an empty buffer
         wait_drained();
         stall = 1'b1;
         @(negedge clk);
      end
      if (e.stall) begin
         check(32'(ready), 32'd1, "ready while the write buffer has room");
      end else begin
         while (!ready) begin
            @(negedge clk);
         end
      end
      avalid = 1'b1;
      addr   = e.addr;
      wdata  = e.wdata;
      wstrb  = e.wstrb;
      for (int b = 0; b < NBYTES; b++) begin
         if (e.wstrb[b]) begin
            shadow[w][8*b +: 8] = e.wdata[8*b +: 8];
         end
      end
      wq_addr.push_back(e.addr);
      wq_data.push_back(e.wdata);
      wq_strb.push_back(e.wstrb);
      wr_issued++;
      @(negedge clk);
      avalid = 1'b0;
   endtask

   task automatic read_entry(input entry_t e);
      cache_addr_u a;
      int          way;
      int          base;
      logic        miss;
      a.raw = e.addr;
      miss  = (find_way(e.addr) < 0);
      check(32'(miss), 32'(e.fetch), "cache model against the table read flag");
      while (!ready) begin
         @(negedge clk);
      end
      base    = rd_seen;
      rd_addr = e.addr;
      avalid  = 1'b1;
      addr    = e.addr;
      wdata   = '0;
      wstrb   = '0;
      @(negedge clk);
      avalid = 1'b0;
      if (!miss) begin
         check(32'(rvalid), 32'd1, "rvalid in the cycle after a read hit");
      end else begin
         check(32'(rvalid), 32'd0, "rvalid in the cycle after a read miss");
         while (!rvalid) begin
            @(negedge clk);
         end
         // victim way takes the line and the set pointer moves on
         way = ptr_m[a.f.index];
         line_m[way][a.f.index] = {1'b1, a.f.tag};
         ptr_m[a.f.index] = (way + 1) % NWAYS;
      end
      check(rdata, shadow[e.addr[ADDR_W-1:OFFSET_W]], "read data");
      check(32'(rd_seen - base), 32'(e.fetch), "backend reads for one request");
   endtask

   // memory stalled with a full buffer so nothing more may enter
   task automatic hold_full();
      repeat (8) begin
         check(32'(ready), 32'd0, "ready with a full write buffer");
         @(negedge clk);
      end
      // oldest write waits on the backend bus
      check(32'(be_avalid), 32'd1, "backend valid with a stalled write buffer");
      check(32'(be_addr), 32'(wq_addr[0]), "stalled backend write address");
      check(be_wdata, wq_data[0], "stalled backend write data");
      stall = 1'b0;
      wait_drained();
   endtask

   initial begin
      entry_t e;
      tbl[0]  = '{OP_RD,    1'b0, 12'h010, 32'h0000_0000, 4'b0000, 1'b1};
      tbl[1]  = '{OP_RD,    1'b0, 12'h010, 32'h0000_0000, 4'b0000, 1'b0};
      tbl[2]  = '{OP_WR,    1'b0, 12'h010, 32'hdead_beef, 4'b0110, 1'b0};
      tbl[3]  = '{OP_RD,    1'b0, 12'h010, 32'h0000_0000, 4'b0000, 1'b0};
      tbl[4]  = '{OP_DRAIN, 1'b0, 12'h010, 32'h0000_0000, 4'b0000, 1'b0};
      tbl[5]  = '{OP_WR,    1'b0, 12'h200, 32'h1234_5678, 4'b1111, 1'b0};
      tbl[6]  = '{OP_RD,    1'b0, 12'h200, 32'h0000_0000, 4'b0000, 1'b1};
      // same set, three tags
      tbl[7]  = '{OP_RD,    1'b0, 12'h054, 32'h0000_0000, 4'b0000, 1'b1};
      tbl[8]  = '{OP_RD,    1'b0, 12'h094, 32'h0000_0000, 4'b0000, 1'b1};
      tbl[9]  = '{OP_RD,    1'b0, 12'h0d4, 32'h0000_0000, 4'b0000, 1'b1};
      tbl[10] = '{OP_RD,    1'b0, 12'h094, 32'h0000_0000, 4'b0000, 1'b0};
      tbl[11] = '{OP_RD,    1'b0, 12'h054, 32'h0000_0000, 4'b0000, 1'b1};
      tbl[12] = '{OP_WR,    1'b1, 12'h300, 32'ha0a0_0001, 4'b1111, 1'b0};
      tbl[13] = '{OP_WR,    1'b1, 12'h304, 32'ha0a0_0002, 4'b0011, 1'b0};
      tbl[14] = '{OP_WR,    1'b1, 12'h010, 32'hc3c3_c3c3, 4'b1001, 1'b0};
      tbl[15] = '{OP_WR,    1'b1, 12'h308, 32'ha0a0_0004, 4'b1100, 1'b0};
      tbl[16] = '{OP_FULL,  1'b1, 12'h000, 32'h0000_0000, 4'b0000, 1'b0};
      tbl[17] = '{OP_DRAIN, 1'b0, 12'h010, 32'h0000_0000, 4'b0000, 1'b0};
      tbl[18] = '{OP_RD,    1'b0, 12'h010, 32'h0000_0000, 4'b0000, 1'b0};
      for (int i = 0; i < (1 << WORD_AW); i++) begin
         shadow[i] = fill_word(WORD_AW'(i));
      end
      for (int s = 0; s < NSETS; s++) begin
         ptr_m[s] = 0;
         for (int w = 0; w < NWAYS; w++) begin
            line_m[w][s] = '0;
         end
      end
      rst       = 1'b1;
      avalid    = 1'b0;
      addr      = '0;
      wdata     = '0;
      wstrb     = '0;
      stall     = 1'b0;
      rd_addr   = '0;
      wr_issued = 0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < NUM_ENT; i++) begin
         e = tbl[i];
         case (e.op)
            OP_RD: read_entry(e);
            OP_WR: write_entry(e);
            OP_DRAIN: begin
               wait_drained();
               check(u_mem.mem[e.addr[ADDR_W-1:OFFSET_W]], shadow[e.addr[ADDR_W-1:OFFSET_W]],
                     "memory word after the buffer drained");
            end
            default: hold_full();
         endcase
      end
      wait_drained();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

/* files.f */
cache_pkg.sv
cache_way.sv
cache_hit_select.sv
cache_ctrl.sv
cache_backend.sv
cache_top.sv
tb_mem_model.sv
cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f files.f --top-module cache_tb -o cache_sim \
   && ./obj_dir/cache_sim > sim.log 2>&1

test -f sim.log || { echo "simulation did not run"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation passed"
